//--- include/mips_settings.svh
//========================================
// mips settings
// global sizing for the single-cycle core,
// its register file and the data SRAM
//========================================
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// data path and address width
`define WORD_W 32

// architectural registers, zero included
`define REG_COUNT 32

// data memory words, the one knob meant to change
`define DMEM_DEPTH 128
// word index width into the SRAM
`define DMEM_AW ($clog2(`DMEM_DEPTH))

// program limits
`define RESET_PC 32'h0000_0000
`define PROG_MAX_WORDS 256

`endif

//--- rtl/mips_pkg.sv
//========================================
// mips package
// shared field types, opcode / funct
// codes and the ALU control encoding
//========================================
`include "mips_settings.svh"

package mips_pkg;
  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [4:0] regIdx_t;
  typedef logic [5:0] opcode_t;
  typedef logic [5:0] funct_t;
  typedef logic [3:0] aluCtrl_t;

  // main opcodes
  localparam opcode_t opRType = 6'b000000;
  localparam opcode_t opAddi  = 6'b001000;
  localparam opcode_t opLw    = 6'b100011;
  localparam opcode_t opSw    = 6'b101011;
  localparam opcode_t opBeq   = 6'b000100;
  localparam opcode_t opJ     = 6'b000010;
  localparam opcode_t opJal   = 6'b000011;

  // R group function codes
  localparam funct_t fnAdd = 6'b100000;
  localparam funct_t fnSub = 6'b100010;
  localparam funct_t fnAnd = 6'b100100;
  localparam funct_t fnOr  = 6'b100101;
  localparam funct_t fnSlt = 6'b101010;
  localparam funct_t fnSll = 6'b000000;
  localparam funct_t fnSrl = 6'b000010;
  localparam funct_t fnJr  = 6'b001000;

  // ALU operations, classic textbook codes plus two shifts
  localparam aluCtrl_t aluAnd = 4'b0000;
  localparam aluCtrl_t aluOr  = 4'b0001;
  localparam aluCtrl_t aluAdd = 4'b0010;
  localparam aluCtrl_t aluSub = 4'b0110;
  localparam aluCtrl_t aluSlt = 4'b0111;
  localparam aluCtrl_t aluSll = 4'b1000;
  localparam aluCtrl_t aluSrl = 4'b1001;

  // jal return address register
  localparam regIdx_t linkIdx = 5'd31;
endpackage

//--- rtl/instrDecoder.sv
//========================================
// instrDecoder
// main control plus ALU control, decoded
// from the opcode and function fields
//========================================
`timescale 1ns/1ps

module instrDecoder import mips_pkg::*; (
  input  opcode_t  opcode,
  input  funct_t   funct,
  output logic     regDst,
  output logic     aluSrc,
  output logic     memToReg,
  output logic     regWrite,
  output logic     memRead,
  output logic     memWrite,
  output logic     branch,
  output logic     jump,
  output logic     link,
  output logic     jumpReg,
  output logic     shiftOp,
  output aluCtrl_t aluCtrl
);

  always_comb begin
    // defaults: nothing written, nothing accessed
    {regDst, aluSrc, memToReg, regWrite} = 4'b0000;
    {memRead, memWrite, branch, jump} = 4'b0000;
    {link, jumpReg, shiftOp} = 3'b000;
    aluCtrl = aluAdd;
    case (opcode)
      opRType: begin
        regDst   = 1'b1;
        regWrite = 1'b1;
        // operation comes from funct
        case (funct)
          fnAdd: aluCtrl = aluAdd;
          fnSub: aluCtrl = aluSub;
          fnAnd: aluCtrl = aluAnd;
          fnOr:  aluCtrl = aluOr;
          fnSlt: aluCtrl = aluSlt;
          fnSll: begin
            aluCtrl = aluSll;
            shiftOp = 1'b1;
          end
          fnSrl: begin
            aluCtrl = aluSrl;
            shiftOp = 1'b1;
          end
          // jr redirects pc, no register write
          fnJr: begin
            regWrite = 1'b0;
            jumpReg  = 1'b1;
          end
          default: regWrite = 1'b0;
        endcase
      end
      opAddi: begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
      end
      opLw: begin
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
      end
      opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      // compare by subtraction, zero flag decides
      opBeq: begin
        branch  = 1'b1;
        aluCtrl = aluSub;
      end
      opJ: jump = 1'b1;
      opJal: begin
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: ;
    endcase
  end

  // the SRAM port is either read or written, never both
  always_comb begin
    assert (!(memRead && memWrite))
      else $error("instrDecoder: load and store decoded together");
  end

endmodule

//--- rtl/regFile.sv
//========================================
// regFile
// 31 general registers and a hard zero,
// two async read ports, one write port
//========================================
`timescale 1ns/1ps
`include "mips_settings.svh"

module regFile import mips_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  regIdx_t rdIdx1,
  input  regIdx_t rdIdx2,
  input  regIdx_t wrIdx,
  input  logic    wrEn,
  input  word_t   wrData,
  output word_t   rdData1,
  output word_t   rdData2
);

  // register 0 has no storage
  word_t regs [1:`REG_COUNT-1];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrIdx != '0)) begin
      regs[wrIdx] <= wrData;
    end
  end

  // reads see the value before this cycle's write
  assign rdData1 = (rdIdx1 == '0) ? '0 : regs[rdIdx1];
  assign rdData2 = (rdIdx2 == '0) ? '0 : regs[rdIdx2];

  // a write must name a real register
  assert property (@(posedge clk) disable iff (!rst) wrEn |-> !$isunknown(wrIdx))
    else $error("regFile: write with unknown index");

endmodule

//--- rtl/alu.sv
//========================================
// alu
// add, sub, and, or, signed slt and the
// two logical shifts, with zero flag
//========================================
`timescale 1ns/1ps

module alu import mips_pkg::*; (
  input  word_t    a,
  input  word_t    b,
  input  regIdx_t  shamt,
  input  aluCtrl_t aluCtrl,
  output word_t    result,
  output logic     zero
);

  always_comb begin
    case (aluCtrl)
      aluAdd: result = a + b;
      aluSub: result = a - b;
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      // signed compare, result is 0 or 1
      aluSlt: result = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
      // shifts act on the rt operand
      aluSll: result = b << shamt;
      aluSrl: result = b >> shamt;
      default: result = '0;
    endcase
  end

  // flag on any zero result, beq tests it after sub
  assign zero = (result == '0);

endmodule

//--- rtl/pcUnit.sv
//========================================
// pcUnit
// program counter and next-address pick
// among jr, jump, branch and pc + 4
//========================================
`timescale 1ns/1ps
`include "mips_settings.svh"

module pcUnit import mips_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        branch,
  input  logic        jump,
  input  logic        jumpReg,
  input  logic        aluZero,
  input  word_t       offset,
  input  logic [25:0] target,
  input  word_t       rsValue,
  output word_t       pc,
  output word_t       pcPlus4
);

  word_t pcNext;
  word_t branchAddr;
  word_t jumpAddr;

  assign pcPlus4 = pc + word_t'(4);
  // offset counts words
  assign branchAddr = pcPlus4 + (offset << 2);
  // region bits kept from pc + 4
  assign jumpAddr = {pcPlus4[`WORD_W-1:`WORD_W-4], target, 2'b00};

  // priority: jr, j / jal, taken beq, sequential
  always_comb begin
    if (jumpReg) begin
      pcNext = rsValue;
    end else if (jump) begin
      pcNext = jumpAddr;
    end else if (branch && aluZero) begin
      pcNext = branchAddr;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= pcNext;
    end
  end

  // jr may load anything, fetches stay on word boundaries
  assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
    else $error("pcUnit: misaligned pc %h", pc);

endmodule

//--- rtl/dataSram.sv
//========================================
// dataSram
// word-wide data memory, active-low chip,
// write and output enables
//========================================
`timescale 1ns/1ps
`include "mips_settings.svh"

module dataSram import mips_pkg::*; (
  input  logic               clk,
  input  logic               cen,
  input  logic               wen,
  input  logic               oen,
  input  logic [`DMEM_AW-1:0] addr,
  input  word_t              wData,
  output word_t              rData
);

  word_t mem [0:`DMEM_DEPTH-1];

  // ========================================
  // write port
  // ========================================
  always_ff @(posedge clk) begin
    if (!cen && !wen) begin
      mem[addr] <= wData;
    end
  end

  // ========================================
  // read port
  // ========================================
  // flow-through, bus idles at zero
  assign rData = (!cen && !oen) ? mem[addr] : '0;

  // write and output drive never overlap
  assert property (@(posedge clk) !(!wen && !oen))
    else $error("dataSram: wen and oen low together");

endmodule

//--- rtl/mipsCore.sv
//========================================
// mipsCore
// single-cycle datapath: field split,
// operand / write-back muxes, PC, decoder,
// register file and ALU
//========================================
`timescale 1ns/1ps
`include "mips_settings.svh"

module mipsCore import mips_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  word_t              instr,
  output word_t              instrAddr,
  output logic               cen,
  output logic               wen,
  output logic               oen,
  output logic [`DMEM_AW-1:0] memAddr,
  output word_t              memWData,
  input  word_t              memRData,
  output logic               wbEn,
  output regIdx_t            wbIdx,
  output word_t              wbData
);

  // instruction fields
  opcode_t     opcode;
  funct_t      funct;
  regIdx_t     rsIdx;
  regIdx_t     rtIdx;
  regIdx_t     rdIdx;
  regIdx_t     instrShamt;
  logic [15:0] imm16;
  logic [25:0] target;
  // control
  logic        regDst, aluSrc, memToReg, regWrite;
  logic        memRead, memWrite, branch, jump;
  logic        link, jumpReg, shiftOp;
  aluCtrl_t    aluCtrl;
  // datapath
  word_t       signExt, rsValue, rtValue, aluB, aluResult;
  word_t       pc, pcPlus4;
  regIdx_t     shamtSel;
  logic        aluZero;

  // ========================================
  // field split
  // ========================================
  assign opcode     = instr[31:26];
  assign rsIdx      = instr[25:21];
  assign rtIdx      = instr[20:16];
  assign rdIdx      = instr[15:11];
  assign instrShamt = instr[10:6];
  assign funct      = instr[5:0];
  assign imm16      = instr[15:0];
  assign target     = instr[25:0];
  assign signExt    = {{(`WORD_W-16){imm16[15]}}, imm16};

  instrDecoder uDec (
    .opcode, .funct, .regDst, .aluSrc, .memToReg, .regWrite, .memRead,
    .memWrite, .branch, .jump, .link, .jumpReg, .shiftOp, .aluCtrl
  );

  regFile uRegs (
    .clk, .rst, .rdIdx1(rsIdx), .rdIdx2(rtIdx), .wrIdx(wbIdx), .wrEn(wbEn),
    .wrData(wbData), .rdData1(rsValue), .rdData2(rtValue)
  );

  // ========================================
  // execute
  // ========================================
  // immediate for addi / lw / sw, rt otherwise
  assign aluB = aluSrc ? signExt : rtValue;
  // shift amount only for sll / srl
  assign shamtSel = shiftOp ? instrShamt : '0;

  alu uAlu (
    .a(rsValue), .b(aluB), .shamt(shamtSel), .aluCtrl, .result(aluResult), .zero(aluZero)
  );

  pcUnit uPc (
    .clk, .rst, .branch, .jump, .jumpReg, .aluZero, .offset(signExt), .target,
    .rsValue, .pc, .pcPlus4
  );

  assign instrAddr = pc;

  // ========================================
  // memory and write-back
  // ========================================
  // enables held inactive while in reset
  assign cen      = !(rst && (memRead || memWrite));
  assign wen      = !(rst && memWrite);
  assign oen      = !(rst && memRead);
  assign memAddr  = aluResult[`DMEM_AW+1:2];
  assign memWData = rtValue;

  assign wbEn   = rst && regWrite;
  // jal links through r31
  assign wbIdx  = link ? linkIdx : (regDst ? rdIdx : rtIdx);
  assign wbData = memToReg ? memRData : (link ? pcPlus4 : aluResult);

endmodule

//--- rtl/mipsSystem.sv
//========================================
// mipsSystem
// core plus data SRAM, instruction memory
// stays outside
//========================================
`timescale 1ns/1ps
`include "mips_settings.svh"

module mipsSystem import mips_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  word_t   instr,
  output word_t   instrAddr,
  output logic    wbEn,
  output regIdx_t wbIdx,
  output word_t   wbData
);

  // core to SRAM
  logic               cen, wen, oen;
  logic [`DMEM_AW-1:0] memAddr;
  word_t              memWData;
  word_t              memRData;

  mipsCore uCore (
    .clk, .rst, .instr, .instrAddr, .cen, .wen, .oen, .memAddr, .memWData,
    .memRData, .wbEn, .wbIdx, .wbData
  );

  dataSram uSram (
    .clk, .cen, .wen, .oen, .addr(memAddr), .wData(memWData), .rData(memRData)
  );

endmodule

//--- tb/mipsTb.sv
//========================================
// mipsTb
// testbench for the single-cycle MIPS
// system: instruction memory model,
// instruction-level reference, checks
//========================================
`timescale 1ns/1ps
`include "mips_settings.svh"

module mipsTb import mips_pkg::*; ();

  localparam int NUM_TESTS = 6;
  localparam int PROG_WORDS = `PROG_MAX_WORDS;
  localparam int RESET_CYCLES = 10;
  localparam logic [31:0] SEED = 32'h3e88_9221;
  // beq r0, r0, -1
  localparam word_t SELF_LOOP = 32'h1000_ffff;

  logic    clk;
  logic    rst;
  word_t   instr;
  word_t   instrAddr;
  logic    wbEn;
  regIdx_t wbIdx;
  word_t   wbData;

  // programs, one row per test
  word_t progMem [NUM_TESTS][PROG_WORDS];
  int    progLen [NUM_TESTS];
  string testName [NUM_TESTS] = '{"r-type alu", "shifts and addi", "store and load",
                                  "beq", "jumps", "register zero"};
  int    curTest;
  logic  checking;

  // reference state
  word_t mRegs [`REG_COUNT];
  word_t mMem [0:`DMEM_DEPTH-1];
  word_t mPc;

  int errorCount;
  int testErrors;
  int checkCount;
  int passCount;
  int cycleCount;
  int cycleLimit;

  mipsSystem DUT (
    .clk, .rst, .instr, .instrAddr, .wbEn, .wbIdx, .wbData
  );

  always #4 clk = ~clk;

  // ========================================
  // program building
  // ========================================
  function automatic word_t encodeR(funct_t fn, regIdx_t rd, regIdx_t rs, regIdx_t rt,
                                    logic [4:0] sh);
    return {opRType, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t encodeI(opcode_t op, regIdx_t rt, regIdx_t rs,
                                    logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t encodeJ(opcode_t op, logic [25:0] tgt);
    return {op, tgt};
  endfunction

  function automatic logic [15:0] randImm();
    return 16'($urandom);
  endfunction

  // random register in lo..hi
  function automatic regIdx_t pickReg(int lo, int hi);
    return regIdx_t'(lo + int'($urandom % (hi - lo + 1)));
  endfunction

  task automatic appendInstr(input int t, input word_t w);
    progMem[t][progLen[t]] = w;
    progLen[t]++;
  endtask

  task automatic buildAluTest(input int t);
    funct_t ops [5];
    ops = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt};
    for (int r = 1; r <= 6; r++) begin
      appendInstr(t, encodeI(opAddi, regIdx_t'(r), 5'd0, randImm()));
    end
    for (int k = 0; k < 10; k++) begin
      appendInstr(t, encodeR(ops[k % 5], pickReg(7, 15), pickReg(1, 6), pickReg(1, 6), 5'd0));
    end
  endtask

  task automatic buildShiftTest(input int t);
    logic [15:0] imm;
    for (int r = 1; r <= 4; r++) begin
      imm = randImm();
      // two sources forced negative
      if (r > 2) begin
        imm[15] = 1'b1;
      end
      appendInstr(t, encodeI(opAddi, regIdx_t'(r), 5'd0, imm));
    end
    for (int k = 0; k < 8; k++) begin
      appendInstr(t, encodeR((k % 2 == 1) ? fnSrl : fnSll, pickReg(5, 12), 5'd0,
                             pickReg(1, 4), 5'($urandom % 32)));
    end
    for (int k = 0; k < 3; k++) begin
      imm = 16'(-1 - int'($urandom % 1000));
      appendInstr(t, encodeI(opAddi, pickReg(13, 15), pickReg(1, 4), imm));
    end
  endtask

  task automatic buildMemTest(input int t);
    int a [4];
    // one address per quarter, so all differ
    for (int i = 0; i < 4; i++) begin
      a[i] = 32 * i + int'($urandom % 32);
    end
    for (int r = 2; r <= 6; r++) begin
      appendInstr(t, encodeI(opAddi, regIdx_t'(r), 5'd0, randImm()));
    end
    for (int i = 0; i < 4; i++) begin
      appendInstr(t, encodeI(opSw, regIdx_t'(i + 2), 5'd0, 16'(a[i] * 4)));
    end
    // overwrite of the second word
    appendInstr(t, encodeI(opSw, 5'd6, 5'd0, 16'(a[1] * 4)));
    appendInstr(t, encodeI(opAddi, 5'd7, 5'd0, 16'd16));
    appendInstr(t, encodeI(opLw, 5'd10, 5'd0, 16'(a[0] * 4)));
    appendInstr(t, encodeI(opLw, 5'd11, 5'd0, 16'(a[1] * 4)));
    appendInstr(t, encodeI(opLw, 5'd12, 5'd0, 16'(a[3] * 4)));
    // base register plus offset
    appendInstr(t, encodeI(opLw, 5'd13, 5'd7, 16'(a[2] * 4 - 16)));
  endtask

  task automatic buildBranchTest(input int t);
    appendInstr(t, encodeI(opAddi, 5'd1, 5'd0, 16'(2 + int'($urandom % 3))));
    appendInstr(t, encodeI(opAddi, 5'd2, 5'd0, 16'd0));
    // loop body at word 2
    appendInstr(t, encodeI(opAddi, 5'd2, 5'd2, 16'd5));
    appendInstr(t, encodeI(opAddi, 5'd1, 5'd1, 16'hffff));
    // exit forward once the counter hits zero
    appendInstr(t, encodeI(opBeq, 5'd0, 5'd1, 16'd1));
    // backward to word 2
    appendInstr(t, encodeI(opBeq, 5'd0, 5'd0, 16'hfffc));
    appendInstr(t, encodeI(opBeq, 5'd1, 5'd2, 16'd2));
    appendInstr(t, encodeI(opAddi, 5'd4, 5'd0, 16'd7));
    appendInstr(t, encodeI(opBeq, 5'd4, 5'd4, 16'd1));
    appendInstr(t, encodeI(opAddi, 5'd5, 5'd0, 16'd99));
    appendInstr(t, encodeI(opAddi, 5'd6, 5'd2, randImm()));
  endtask

  task automatic buildJumpTest(input int t);
    appendInstr(t, encodeI(opAddi, 5'd1, 5'd0, randImm()));
    // call the routine at word 4, return lands on word 2
    appendInstr(t, encodeJ(opJal, 26'd4));
    appendInstr(t, encodeI(opAddi, 5'd2, 5'd1, 16'd1));
    appendInstr(t, encodeJ(opJ, 26'd6));
    appendInstr(t, encodeI(opAddi, 5'd3, 5'd1, 16'd2));
    appendInstr(t, encodeR(fnJr, 5'd0, 5'd31, 5'd0, 5'd0));
    appendInstr(t, encodeR(fnAdd, 5'd4, 5'd2, 5'd3, 5'd0));
    appendInstr(t, encodeI(opAddi, 5'd5, 5'd31, randImm()));
  endtask

  task automatic buildZeroRegTest(input int t);
    appendInstr(t, encodeI(opAddi, 5'd1, 5'd0, randImm()));
    appendInstr(t, encodeI(opAddi, 5'd0, 5'd0, randImm()));
    appendInstr(t, encodeR(fnAdd, 5'd0, 5'd1, 5'd1, 5'd0));
    appendInstr(t, encodeR(fnSll, 5'd0, 5'd0, 5'd1, 5'd3));
    // r0 still reads zero below
    appendInstr(t, encodeR(fnAdd, 5'd2, 5'd0, 5'd0, 5'd0));
    appendInstr(t, encodeR(fnOr, 5'd3, 5'd0, 5'd1, 5'd0));
    appendInstr(t, encodeR(fnSub, 5'd4, 5'd1, 5'd0, 5'd0));
    appendInstr(t, encodeR(fnSlt, 5'd5, 5'd0, 5'd1, 5'd0));
  endtask

  // instruction memory, branch-to-self past the end
  function automatic word_t fetchWord(int t, word_t addr);
    if (addr < word_t'(progLen[t] * 4)) begin
      return progMem[t][int'(addr[15:2])];
    end
    return SELF_LOOP;
  endfunction

  // ========================================
  // reference model
  // ========================================
  function automatic void refStep(output logic en, output regIdx_t idx, output word_t data);
    word_t ins, simm, rsV, rtV, ea, pc4, pcNext;
    ins = fetchWord(curTest, mPc);
    simm = {{16{ins[15]}}, ins[15:0]};
    rsV = mRegs[ins[25:21]];
    rtV = mRegs[ins[20:16]];
    ea = rsV + simm;
    pc4 = mPc + 32'd4;
    pcNext = pc4;
    en = 1'b0;
    idx = '0;
    data = '0;
    case (ins[31:26])
      opRType: begin
        en = 1'b1;
        idx = ins[15:11];
        case (ins[5:0])
          fnAdd: data = rsV + rtV;
          fnSub: data = rsV - rtV;
          fnAnd: data = rsV & rtV;
          fnOr:  data = rsV | rtV;
          fnSlt: data = ($signed(rsV) < $signed(rtV)) ? 32'd1 : 32'd0;
          fnSll: data = rtV << ins[10:6];
          fnSrl: data = rtV >> ins[10:6];
          fnJr: begin
            en = 1'b0;
            pcNext = rsV;
          end
          default: en = 1'b0;
        endcase
      end
      opAddi: begin
        en = 1'b1;
        idx = ins[20:16];
        data = ea;
      end
      opLw: begin
        en = 1'b1;
        idx = ins[20:16];
        data = mMem[ea[`DMEM_AW+1:2]];
      end
      opSw: mMem[ea[`DMEM_AW+1:2]] = rtV;
      opBeq: begin
        if (rsV == rtV) begin
          pcNext = pc4 + (simm << 2);
        end
      end
      opJ: pcNext = {pc4[31:28], ins[25:0], 2'b00};
      opJal: begin
        en = 1'b1;
        idx = 5'd31;
        data = pc4;
        pcNext = {pc4[31:28], ins[25:0], 2'b00};
      end
      default: ;
    endcase
    if (en && idx != '0) begin
      mRegs[idx] = data;
    end
    mPc = pcNext;
  endfunction

  // ========================================
  // checks
  // ========================================
  task automatic checkWord(input string what, input word_t got, input word_t exp);
    checkCount++;
    if (got !== exp) begin
      $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
      errorCount++;
      testErrors++;
    end
  endtask

  task automatic checkIdx(input string what, input regIdx_t got, input regIdx_t exp);
    checkCount++;
    if (got !== exp) begin
      $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errorCount++;
      testErrors++;
    end
  endtask

  task automatic checkBit(input string what, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      $display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
      errorCount++;
      testErrors++;
    end
  endtask

  // instruction memory answers on the falling edge
  always @(negedge clk) begin
    instr = fetchWord(curTest, instrAddr);
  end

  // outputs settled since the falling edge
  always @(posedge clk) begin : compare
    logic    expEn;
    regIdx_t expIdx;
    word_t   expData;
    if (checking) begin
      checkWord("instrAddr", instrAddr, mPc);
      refStep(expEn, expIdx, expData);
      checkBit("wbEn", wbEn, expEn);
      if (expEn) begin
        checkIdx("wbIdx", wbIdx, expIdx);
        checkWord("wbData", wbData, expData);
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("timeout: no end of program after %0d cycles", cycleLimit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic runTest(input int t);
    @(negedge clk);
    curTest = t;
    rst = 1'b0;
    testErrors = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    checkWord("reset instrAddr", instrAddr, '0);
    checkBit("reset wbEn", wbEn, 1'b0);
    foreach (mRegs[i]) begin
      mRegs[i] = '0;
    end
    mPc = `RESET_PC;
    rst = 1'b1;
    checking = 1'b1;
    // model pc reaching the end marks done
    while (mPc != word_t'(progLen[t] * 4)) begin
      @(negedge clk);
    end
    checking = 1'b0;
    // next address after the last instruction
    checkWord("final instrAddr", instrAddr, mPc);
    if (testErrors == 0) begin
      passCount++;
      $display("test %0d %s: ok", t, testName[t]);
    end else begin
      $display("test %0d %s: %0d errors", t, testName[t], testErrors);
    end
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    int total;
    clk = 1'b0;
    rst = 1'b0;
    instr = SELF_LOOP;
    checking = 1'b0;
    curTest = 0;
    errorCount = 0;
    checkCount = 0;
    passCount = 0;
    cycleCount = 0;
    cycleLimit = 0;
    void'($urandom(SEED));
    foreach (progLen[i]) begin
      progLen[i] = 0;
    end
    buildAluTest(0);
    buildShiftTest(1);
    buildMemTest(2);
    buildBranchTest(3);
    buildJumpTest(4);
    buildZeroRegTest(5);
    total = 0;
    foreach (progLen[i]) begin
      total += progLen[i];
    end
    cycleLimit = 2 * (total + NUM_TESTS * RESET_CYCLES);
    for (int t = 0; t < NUM_TESTS; t++) begin
      runTest(t);
    end
    $display("tests %0d, passed %0d, checks %0d, errors %0d",
             NUM_TESTS, passCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+include
rtl/mips_pkg.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/alu.sv
rtl/pcUnit.sv
rtl/dataSram.sv
rtl/mipsCore.sv
rtl/mipsSystem.sv
tb/mipsTb.sv

//--- run.sh
#!/bin/sh
# build and run the MIPS testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module mipsTb -o mipsSim

./obj_dir/mipsSim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation reported errors"
  exit 1
fi

echo "simulation finished without errors"
